//--- design/addr_decoder.sv
// Combinational decode of one CPU data access into device strobes.
// Nibbles 0 and 8 both reach DRAM; the host command address decodes as DEV_NONE.
// Strobes follow data_we/data_re in the same cycle and carry no back-pressure.
`timescale 1ns/1ps
`default_nettype none
`include "mem_map_cfg.svh"

module addr_decoder
    import bus_pkg::*;
(
    input  wire [31:0]                         data_addr,
    input  wire [31:0]                         data_wdata,
    input  wire load_ctrl_e                    data_ctrl,
    input  wire                                data_we,
    input  wire                                data_re,
    output bus_dev_e                           dev,
    output logic                               cpu_dram_rd,
    output logic                               cpu_dram_wr,
    output logic [31:0]                        cpu_dram_addr,
    output logic                               plic_we,
    output logic                               plic_re,
    output logic [31:0]                        plic_wdata,
    output logic                               clint_we,
    output logic [31:0]                        clint_wdata,
    output logic                               fb_we,
    output logic [31:0]                        fb_wdata,
    output logic [$bits(`DRAM_ADDR_MASK)-1:0] offset,
    output logic                               tohost_we
);

    logic [3:0] top_nib;
    logic [3:0] virt_nib;

    assign top_nib  = data_addr[31:28];
    assign virt_nib = data_addr[27:24];

    always_comb begin
        if (top_nib == `MEM_DEV || top_nib == 4'h0)
            dev = DEV_DRAM;
        else if (top_nib == `PLIC_DEV)
            dev = DEV_PLIC;
        else if (top_nib == `CLINT_DEV)
            dev = DEV_CLINT;
        else if (top_nib == `VIRTIO_DEV && virt_nib == `FB_VIRT)
            dev = DEV_FB;
        else
            dev = DEV_NONE;
    end

    // Physical offset inside the selected window
    assign offset        = data_addr[$bits(`DRAM_ADDR_MASK)-1:0] & `DRAM_ADDR_MASK;
    assign cpu_dram_addr = {{(32 - $bits(`DRAM_ADDR_MASK)){1'b0}}, offset};

    assign cpu_dram_rd = data_re && (dev == DEV_DRAM);
    assign cpu_dram_wr = data_we && (dev == DEV_DRAM);
    assign plic_we     = data_we && (dev == DEV_PLIC);
    assign plic_re     = data_re && (dev == DEV_PLIC);
    assign clint_we    = data_we && (dev == DEV_CLINT);
    assign fb_we       = data_we && (dev == DEV_FB);
    assign tohost_we   = data_we && (data_addr == `TOHOST_ADDR);

    assign plic_wdata  = data_wdata;
    assign clint_wdata = data_wdata;
    assign fb_wdata    = data_wdata;

    // Load and store strobes are exclusive, loads carry a legal width
    always_comb begin
        assert #0 (!(data_we && data_re));
        assert #0 (!data_re || data_ctrl inside {LD_B, LD_H, LD_W, LD_BU, LD_HU});
    end

endmodule

`default_nettype wire

//--- design/boot_loader.sv
// Streams the kernel image and then the device tree into DRAM, word by word.
// Loader writes bypass dram_busy, so the loader must not stream while DRAM is busy.
// CPU requests are ignored until init_done; afterwards they pass through gated by dram_busy.
`timescale 1ns/1ps
`default_nettype none
`include "mem_map_cfg.svh"

module boot_loader
    import bus_pkg::*;
    import host_pkg::*;
(
    input  wire             CLK,
    input  wire             rst_n,
    input  wire             loader_we,
    input  wire [31:0]      loader_data,
    input  wire             cpu_dram_rd,
    input  wire             cpu_dram_wr,
    input  wire [31:0]      cpu_dram_addr,
    input  wire [31:0]      data_wdata,
    input  wire load_ctrl_e data_ctrl,
    input  wire             dram_busy,
    output logic            dram_rd_en,
    output logic            dram_wr_en,
    output logic [31:0]     dram_addr,
    output logic [31:0]     dram_wdata,
    output load_ctrl_e      dram_ctrl,
    output logic            init_done,
    output logic [31:0]     checksum
);

    boot_stage_e stage_q;
    boot_stage_e stage_d;
    logic [31:0] boot_addr_q;
    logic [31:0] stage_limit;
    logic        booting;
    logic        last_word;

    assign booting     = (stage_q != BOOT_DONE);
    assign stage_limit = (stage_q == BOOT_KERNEL) ? `BOOT_BYTES : (`DTB_START + `DTB_BYTES);
    assign last_word   = loader_we && booting && ((boot_addr_q + 32'd4) >= stage_limit);

    always_comb begin
        stage_d = stage_q;
        case (stage_q)
            BOOT_KERNEL: if (last_word) stage_d = BOOT_DTB;
            BOOT_DTB:    if (last_word) stage_d = BOOT_DONE;
            default:     stage_d = BOOT_DONE;
        endcase
    end

    always_ff @(posedge CLK or negedge rst_n) begin
        if (!rst_n) begin
            stage_q     <= BOOT_KERNEL;
            boot_addr_q <= 32'h0;
            checksum    <= 32'h0;
        end else begin
            stage_q <= stage_d;
            if (loader_we && booting) begin
                checksum <= checksum + loader_data;
                // Device tree starts at its own base once the kernel is in
                if (stage_q == BOOT_KERNEL && last_word)
                    boot_addr_q <= `DTB_START;
                else
                    boot_addr_q <= boot_addr_q + 32'd4;
            end
        end
    end

    assign init_done = (stage_q == BOOT_DONE);

    // DRAM port ownership
    assign dram_wr_en = booting ? loader_we : (cpu_dram_wr && !dram_busy);
    assign dram_rd_en = booting ? 1'b0 : (cpu_dram_rd && !dram_busy);
    assign dram_addr  = booting ? boot_addr_q : cpu_dram_addr;
    assign dram_wdata = booting ? loader_data : data_wdata;
    assign dram_ctrl  = booting ? LD_W : data_ctrl;

    a_rd_wr_excl: assert property (@(posedge CLK) disable iff (!rst_n)
        !(dram_rd_en && dram_wr_en));
    a_stage_fwd: assert property (@(posedge CLK) disable iff (!rst_n)
        $past(stage_q) <= stage_q);

endmodule

`default_nettype wire

//--- design/bus_pkg.sv
// Bus-side types shared by the decoder, the read path and the boot loader.
// load_ctrl_e follows the RISC-V load funct3 encoding; stores reuse the same width codes.
`default_nettype none

package bus_pkg;

    // Target of a CPU data access
    typedef enum logic [2:0] {
        DEV_DRAM  = 3'd0,
        DEV_PLIC  = 3'd1,
        DEV_CLINT = 3'd2,
        DEV_FB    = 3'd3,
        DEV_NONE  = 3'd4
    } bus_dev_e;

    // Access width and sign handling
    typedef enum logic [2:0] {
        LD_B  = 3'b000,
        LD_H  = 3'b001,
        LD_W  = 3'b010,
        LD_BU = 3'b100,
        LD_HU = 3'b101
    } load_ctrl_e;

endpackage

`default_nettype wire

//--- design/host_pkg.sv
// Host-side types for the host command register and the boot sequence.
`default_nettype none

package host_pkg;

    // Decoded host command word
    typedef enum logic [1:0] {
        CMD_NONE  = 2'd0,
        CMD_PRINT = 2'd1,
        CMD_OFF   = 2'd2
    } host_cmd_e;

    // Boot loader progress, only moves forward
    typedef enum logic [1:0] {
        BOOT_KERNEL = 2'd0,
        BOOT_DTB    = 2'd1,
        BOOT_DONE   = 2'd2
    } boot_stage_e;

endpackage

`default_nettype wire

//--- design/mem_interconnect.sv
// Memory-side crossbar top: CPU data port, boot loader stream, DRAM and device ports.
// One data access per cycle with no back-pressure; dram_busy drops CPU DRAM strobes.
// Load results appear on data_rdata with rdata_valid one cycle after data_re.
`timescale 1ns/1ps
`default_nettype none
`include "mem_map_cfg.svh"

module mem_interconnect
    import bus_pkg::*;
(
    input  wire                                CLK,
    input  wire                                rst_n,
    input  wire [31:0]                         data_addr,
    input  wire [31:0]                         data_wdata,
    input  wire load_ctrl_e                    data_ctrl,
    input  wire                                data_we,
    input  wire                                data_re,
    input  wire                                loader_we,
    input  wire [31:0]                         loader_data,
    input  wire                                dram_busy,
    output logic                               dram_rd_en,
    output logic                               dram_wr_en,
    output logic [31:0]                        dram_addr,
    output logic [31:0]                        dram_wdata,
    output load_ctrl_e                         dram_ctrl,
    input  wire [127:0]                        dram_rdata128,
    output logic                               plic_we,
    output logic                               plic_re,
    output logic [31:0]                        plic_wdata,
    input  wire [31:0]                         plic_rdata,
    output logic                               clint_we,
    output logic [31:0]                        clint_wdata,
    input  wire [31:0]                         clint_rdata,
    output logic                               fb_we,
    output logic [31:0]                        fb_wdata,
    input  wire [31:0]                         fb_rdata,
    output logic [31:0]                        data_rdata,
    output logic                               rdata_valid,
    output logic                               char_we,
    output logic [7:0]                         char_data,
    output logic                               finish,
    output logic                               init_done,
    output logic [31:0]                        checksum,
    output logic [$bits(`DRAM_ADDR_MASK)-1:0] offset
);

    bus_dev_e    dev;
    logic        cpu_dram_rd;
    logic        cpu_dram_wr;
    logic [31:0] cpu_dram_addr;
    logic        tohost_we;

    addr_decoder u_addr_decoder (
        .data_addr(data_addr), .data_wdata(data_wdata), .data_ctrl(data_ctrl),
        .data_we(data_we), .data_re(data_re), .dev(dev),
        .cpu_dram_rd(cpu_dram_rd), .cpu_dram_wr(cpu_dram_wr), .cpu_dram_addr(cpu_dram_addr),
        .plic_we(plic_we), .plic_re(plic_re), .plic_wdata(plic_wdata),
        .clint_we(clint_we), .clint_wdata(clint_wdata),
        .fb_we(fb_we), .fb_wdata(fb_wdata), .offset(offset), .tohost_we(tohost_we)
    );

    read_return u_read_return (
        .CLK(CLK), .rst_n(rst_n), .data_re(data_re), .dev(dev),
        .data_addr(data_addr), .data_ctrl(data_ctrl), .dram_rdata128(dram_rdata128),
        .plic_rdata(plic_rdata), .clint_rdata(clint_rdata), .fb_rdata(fb_rdata),
        .data_rdata(data_rdata), .rdata_valid(rdata_valid)
    );

    tohost_ctrl u_tohost_ctrl (
        .CLK(CLK), .rst_n(rst_n), .tohost_we(tohost_we), .data_wdata(data_wdata),
        .char_we(char_we), .char_data(char_data), .finish(finish)
    );

    boot_loader u_boot_loader (
        .CLK(CLK), .rst_n(rst_n), .loader_we(loader_we), .loader_data(loader_data),
        .cpu_dram_rd(cpu_dram_rd), .cpu_dram_wr(cpu_dram_wr), .cpu_dram_addr(cpu_dram_addr),
        .data_wdata(data_wdata), .data_ctrl(data_ctrl), .dram_busy(dram_busy),
        .dram_rd_en(dram_rd_en), .dram_wr_en(dram_wr_en), .dram_addr(dram_addr),
        .dram_wdata(dram_wdata), .dram_ctrl(dram_ctrl),
        .init_done(init_done), .checksum(checksum)
    );

endmodule

`default_nettype wire

//--- design/mem_map_cfg.svh
// Memory map, host command codes and boot image sizes for the memory crossbar.
// Device nibbles select on data_addr[31:28]; the framebuffer sits at nibble 4, sub-nibble 5.
// Boot sizes are byte counts and must be multiples of four.
`ifndef MEM_MAP_CFG_SVH
`define MEM_MAP_CFG_SVH

// Top address nibbles
`define MEM_DEV         4'h8
`define VIRTIO_DEV      4'h4
`define PLIC_DEV        4'h5
`define CLINT_DEV       4'h6

// Second nibble inside the VirtIO window
`define FB_VIRT         4'h5

// Host command register and DRAM offset
`define TOHOST_ADDR     32'h4000_8000
`define DRAM_ADDR_MASK  27'h7ff_ffff

// Upper half of a host command word
`define CMD_PRINT_CHAR  16'h0001
`define CMD_POWER_OFF   16'h0002

// Boot image layout in bytes
`define BOOT_BYTES      32'd64
`define DTB_START       32'h0000_1000
`define DTB_BYTES       32'd32

`endif

//--- design/read_return.sv
// Registers the read target on data_re and forms the load result one cycle later.
// The DRAM line is 128 bits wide; a half or word load must not cross the line end.
// Results of reads dropped by dram_busy are stale but still flagged valid.
`timescale 1ns/1ps
`default_nettype none

module read_return
    import bus_pkg::*;
(
    input  wire             CLK,
    input  wire             rst_n,
    input  wire             data_re,
    input  wire bus_dev_e   dev,
    input  wire [31:0]      data_addr,
    input  wire load_ctrl_e data_ctrl,
    input  wire [127:0]     dram_rdata128,
    input  wire [31:0]      plic_rdata,
    input  wire [31:0]      clint_rdata,
    input  wire [31:0]      fb_rdata,
    output logic [31:0]     data_rdata,
    output logic            rdata_valid
);

    bus_dev_e     dev_q;
    load_ctrl_e   ctrl_q;
    logic [3:0]   byte_q;
    logic [127:0] line_shift;
    logic [31:0]  dram_word;
    logic [31:0]  dram_load;

    always_ff @(posedge CLK or negedge rst_n) begin
        if (!rst_n) begin
            dev_q       <= DEV_NONE;
            rdata_valid <= 1'b0;
        end else begin
            rdata_valid <= data_re;
            if (data_re)
                dev_q <= dev;
        end
    end

    always_ff @(posedge CLK) begin
        if (data_re) begin
            byte_q <= data_addr[3:0];
            ctrl_q <= data_ctrl;
        end
    end

    // Bring the addressed byte down to bit 0
    assign line_shift = dram_rdata128 >> {byte_q, 3'b000};
    assign dram_word  = line_shift[31:0];

    always_comb begin
        case (ctrl_q)
            LD_B:    dram_load = {{24{dram_word[7]}}, dram_word[7:0]};
            LD_BU:   dram_load = {24'h0, dram_word[7:0]};
            LD_H:    dram_load = {{16{dram_word[15]}}, dram_word[15:0]};
            LD_HU:   dram_load = {16'h0, dram_word[15:0]};
            default: dram_load = dram_word;
        endcase
    end

    always_comb begin
        case (dev_q)
            DEV_DRAM:  data_rdata = dram_load;
            DEV_PLIC:  data_rdata = plic_rdata;
            DEV_CLINT: data_rdata = clint_rdata;
            DEV_FB:    data_rdata = fb_rdata;
            default:   data_rdata = 32'h0;
        endcase
    end

endmodule

`default_nettype wire

//--- design/tohost_ctrl.sv
// Host command register: print a character or power the system off.
// A print shows on char_we two cycles after the write and then clears the register.
// Print writes need at least one idle cycle between them; finish stays high until reset.
`timescale 1ns/1ps
`default_nettype none
`include "mem_map_cfg.svh"

module tohost_ctrl
    import host_pkg::*;
(
    input  wire         CLK,
    input  wire         rst_n,
    input  wire         tohost_we,
    input  wire [31:0]  data_wdata,
    output logic        char_we,
    output logic [7:0]  char_data,
    output logic        finish
);

    logic [31:0] tohost_q;
    host_cmd_e   cmd;

    always_comb begin
        if (tohost_q[31:16] == `CMD_PRINT_CHAR)
            cmd = CMD_PRINT;
        else if (tohost_q[31:16] == `CMD_POWER_OFF)
            cmd = CMD_OFF;
        else
            cmd = CMD_NONE;
    end

    always_ff @(posedge CLK or negedge rst_n) begin
        if (!rst_n) begin
            tohost_q <= 32'h0;
            char_we  <= 1'b0;
            finish   <= 1'b0;
        end else begin
            char_we <= (cmd == CMD_PRINT);
            if (cmd == CMD_OFF)
                finish <= 1'b1;
            // A new write wins over the clear after a print
            if (tohost_we)
                tohost_q <= data_wdata;
            else if (cmd == CMD_PRINT)
                tohost_q <= 32'h0;
        end
    end

    always_ff @(posedge CLK) begin
        if (cmd == CMD_PRINT)
            char_data <= tohost_q[7:0];
    end

    // Each print command yields exactly one character strobe
    a_char_single: assert property (@(posedge CLK) disable iff (!rst_n) char_we |=> !char_we);

endmodule

`default_nettype wire

//--- src.f
+incdir+design
design/bus_pkg.sv
design/host_pkg.sv
design/addr_decoder.sv
design/read_return.sv
design/tohost_ctrl.sv
design/boot_loader.sv
design/mem_interconnect.sv
test/tb_clock.sv
test/tb_checker.sv
test/tb_mem_interconnect.sv

//--- test/interconnect_tests.txt
# Columns: name kind addr data ctrl mask expected, numbers in hex
# mask bits: dram_rd_en dram_wr_en plic_we plic_re clint_we fb_we
boot_image boot 10000000 00000100 2 00 80011400
kernel_first peek 00000000 0 0 00 10000000
kernel_last peek 0000003c 0 0 00 10000f00
dtb_first peek 00001000 0 0 00 10001000
dtb_last peek 0000101c 0 0 00 10001700
ld_b_neg load 800002c1 0 0 20 ffffff9b
ld_bu load 800002c1 0 4 20 0000009b
ld_h_neg load 80000286 0 1 20 ffffdddc
ld_hu load 80000286 0 5 20 0000dddc
ld_w_unaligned load 80000215 0 2 20 424d4c4f
ld_b_chain loadb 80000203 0 0 20 00000059
ld_h_chain loadb 00000231 0 1 20 0000686b
ld_w_chain load 80000215 0 2 20 424d4c4f
plic_wr wr 50000010 11223344 2 08 0
clint_wr wr 60000008 55667788 2 02 0
fb_wr wr 45000100 99aabbcc 2 01 0
plic_rd rd 50000004 a1b2c3d4 2 04 a1b2c3d4
clint_rd rd 60000000 0badf00d 2 00 0badf00d
fb_rd rd 45000040 13579bdf 2 00 13579bdf
none_rd rd 70000000 deadbeef 2 00 00000000
dram_wr dwr 80000300 cafef00d 2 10 0
dram_readback load 80000300 0 2 20 cafef00d
busy_rd busy 80000310 0 2 00 0
print_char print 40008000 00010041 2 00 00000041
power_off off 40008000 00020000 2 00 00000001

//--- test/tb_checker.sv
// Watches the DUT outputs and compares them with expected values.
// Load results are expected in strobe order, one cycle after each data_re.
`timescale 1ns/1ps
`default_nettype none

module tb_checker (
    input wire        CLK,
    input wire        rst_n,
    input wire        rdata_valid,
    input wire [31:0] data_rdata,
    input wire        dram_rd_en,
    input wire        dram_wr_en,
    input wire        plic_we,
    input wire        plic_re,
    input wire        clint_we,
    input wire        fb_we,
    input wire [31:0] plic_wdata,
    input wire [31:0] clint_wdata,
    input wire [31:0] fb_wdata
);

    int           mismatch_count = 0;
    int           protocol_count = 0;
    int           cycle_count = 0;
    logic [31:0]  exp_q[$];
    logic [191:0] name_q[$];
    logic         care_q[$];
    int           due_q[$];

    task automatic check_value(input logic [191:0] name, input logic [31:0] exp,
                               input logic [31:0] act);
        if (exp !== act) begin
            mismatch_count++;
            $display("ERROR %0s expected %08h actual %08h", name, exp, act);
        end
    endtask

    // Strobe order: dram_rd_en dram_wr_en plic_we plic_re clint_we fb_we
    task automatic check_strobes(input logic [191:0] name, input logic [5:0] exp_mask);
        check_value(name, {26'h0, exp_mask},
                    {26'h0, dram_rd_en, dram_wr_en, plic_we, plic_re, clint_we, fb_we});
    endtask

    task automatic check_wdata(input logic [191:0] name, input logic [31:0] wdata);
        check_value(name, wdata, plic_wdata);
        check_value(name, wdata, clint_wdata);
        check_value(name, wdata, fb_wdata);
    endtask

    task automatic expect_read(input logic [191:0] name, input logic [31:0] exp,
                               input logic care);
        name_q.push_back(name);
        exp_q.push_back(exp);
        care_q.push_back(care);
        // Result is sampled at the second edge after the strobe
        due_q.push_back(cycle_count + 2);
    endtask

    function automatic int outstanding();
        return exp_q.size();
    endfunction

    always @(posedge CLK) begin
        cycle_count++;
        if (rst_n && (rdata_valid || (due_q.size() > 0 && due_q[0] <= cycle_count))) begin
            if (due_q.size() == 0) begin
                protocol_count++;
                $display("A load result arrived with no read outstanding");
            end else if (!rdata_valid || due_q[0] != cycle_count) begin
                protocol_count++;
                $display("The load result for %0s did not arrive one cycle after its strobe",
                         name_q[0]);
                void'(name_q.pop_front());
                void'(exp_q.pop_front());
                void'(care_q.pop_front());
                void'(due_q.pop_front());
            end else begin
                void'(due_q.pop_front());
                if (care_q.pop_front()) begin
                    check_value(name_q.pop_front(), exp_q.pop_front(), data_rdata);
                end else begin
                    void'(name_q.pop_front());
                    void'(exp_q.pop_front());
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- test/tb_clock.sv
// Testbench clock and reset source: 8 ns period, reset held for 8 cycles.
`timescale 1ns/1ps
`default_nettype none

module tb_clock (
    output logic CLK,
    output logic rst_n
);

    initial CLK = 1'b0;
    always #4 CLK = ~CLK;

    initial begin
        rst_n = 1'b0;
        repeat (8) @(posedge CLK);
        #1 rst_n = 1'b1;
    end

endmodule

`default_nettype wire

//--- test/tb_mem_interconnect.sv
// Testbench top for the memory crossbar; tests come from test/interconnect_tests.txt.
// DRAM model covers byte addresses below 0x2000 only; unwritten bytes read as addr ^ 0x5A.
`timescale 1ns/1ps
`default_nettype none

module tb_mem_interconnect
    import bus_pkg::*;
;

    logic         CLK, rst_n;
    logic [31:0]  data_addr, data_wdata, loader_data;
    load_ctrl_e   data_ctrl, dram_ctrl;
    logic         data_we, data_re, loader_we, dram_busy;
    logic         dram_rd_en, dram_wr_en, plic_we, plic_re, clint_we, fb_we;
    logic [31:0]  dram_addr, dram_wdata, plic_wdata, clint_wdata, fb_wdata;
    logic [31:0]  plic_rdata, clint_rdata, fb_rdata, data_rdata, checksum;
    logic [127:0] dram_rdata128;
    logic         rdata_valid, char_we, finish, init_done;
    logic [7:0]   char_data;
    logic [26:0]  offset;

    logic [7:0]   mem [0:8191];
    int           timeout_count = 0;

    tb_clock u_clock (.CLK(CLK), .rst_n(rst_n));

    mem_interconnect UUT (
        .CLK(CLK), .rst_n(rst_n), .data_addr(data_addr), .data_wdata(data_wdata),
        .data_ctrl(data_ctrl), .data_we(data_we), .data_re(data_re),
        .loader_we(loader_we), .loader_data(loader_data), .dram_busy(dram_busy),
        .dram_rd_en(dram_rd_en), .dram_wr_en(dram_wr_en), .dram_addr(dram_addr),
        .dram_wdata(dram_wdata), .dram_ctrl(dram_ctrl), .dram_rdata128(dram_rdata128),
        .plic_we(plic_we), .plic_re(plic_re), .plic_wdata(plic_wdata),
        .plic_rdata(plic_rdata), .clint_we(clint_we), .clint_wdata(clint_wdata),
        .clint_rdata(clint_rdata), .fb_we(fb_we), .fb_wdata(fb_wdata), .fb_rdata(fb_rdata),
        .data_rdata(data_rdata), .rdata_valid(rdata_valid), .char_we(char_we),
        .char_data(char_data), .finish(finish), .init_done(init_done),
        .checksum(checksum), .offset(offset)
    );

    tb_checker u_checker (
        .CLK(CLK), .rst_n(rst_n), .rdata_valid(rdata_valid), .data_rdata(data_rdata),
        .dram_rd_en(dram_rd_en), .dram_wr_en(dram_wr_en), .plic_we(plic_we),
        .plic_re(plic_re), .clint_we(clint_we), .fb_we(fb_we),
        .plic_wdata(plic_wdata), .clint_wdata(clint_wdata), .fb_wdata(fb_wdata)
    );

    // DRAM model, stores by width and answers reads one cycle later
    initial begin
        for (int i = 0; i < 8192; i++)
            mem[i] = i[7:0] ^ 8'h5a;
        dram_rdata128 = 128'h0;
    end

    always @(posedge CLK) begin
        int nbytes;
        nbytes = (dram_ctrl[1:0] == 2'd0) ? 1 : (dram_ctrl[1:0] == 2'd1) ? 2 : 4;
        if (dram_wr_en)
            for (int i = 0; i < nbytes; i++)
                mem[dram_addr[12:0] + i] <= dram_wdata[8*i +: 8];
        if (dram_rd_en)
            for (int i = 0; i < 16; i++)
                dram_rdata128[8*i +: 8] <= mem[{dram_addr[12:4], 4'h0} + i];
    end

    task automatic next_cycle();
        @(posedge CLK);
        #1;
    endtask

    task automatic cpu_drive(input logic we, input logic re, input logic [31:0] addr,
                             input logic [31:0] wdata, input logic [2:0] ctrl);
        data_addr  = addr;
        data_wdata = wdata;
        data_ctrl  = load_ctrl_e'(ctrl);
        data_we    = we;
        data_re    = re;
    endtask

    task automatic cpu_release();
        data_we = 1'b0;
        data_re = 1'b0;
    endtask

    // Counts cycles from the write strobe until the host output goes high
    task automatic wait_host_output(input logic [191:0] name, input logic use_finish,
                                    output int cycles);
        cycles = 1;
        while (!(use_finish ? finish : char_we) && cycles <= 8) begin
            next_cycle();
            cycles++;
        end
        if (cycles > 8) begin
            timeout_count++;
            $display("Timed out waiting for the host command output in %0s", name);
        end
    endtask

    initial begin
        int           fd, r, cycles, gap;
        logic [1279:0] line;
        logic [191:0] name, kind, first;
        logic [31:0]  addr, data, ctrl, mask, exp;

        void'($urandom(38));
        data_addr = 32'h0;
        data_wdata = 32'h0;
        data_ctrl = LD_W;
        data_we = 1'b0;
        data_re = 1'b0;
        loader_we = 1'b0;
        loader_data = 32'h0;
        dram_busy = 1'b0;
        plic_rdata = 32'h0;
        clint_rdata = 32'h0;
        fb_rdata = 32'h0;

        cycles = 0;
        while (rst_n !== 1'b1 && cycles < 16) begin
            @(posedge CLK);
            cycles++;
        end
        if (rst_n !== 1'b1) begin
            timeout_count++;
            $display("Timed out waiting for the reset to be released");
        end
        next_cycle();
        u_checker.check_strobes("reset_strobes", 6'h0);
        u_checker.check_value("reset_status", 32'h0,
                              {28'h0, rdata_valid, char_we, finish, init_done});

        fd = $fopen("test/interconnect_tests.txt", "r");
        if (fd == 0) begin
            timeout_count++;
            $display("Could not open the tests file");
        end else begin
            while ($fgets(line, fd) != 0) begin
                first = 0;
                if ($sscanf(line, "%s", first) != 1 || first == "#")
                    continue;
                r = $sscanf(line, "%s %s %h %h %h %h %h",
                            name, kind, addr, data, ctrl, mask, exp);
                if (r != 7)
                    continue;
                if (kind == "boot") begin
                    for (int i = 0; i < 24; i++) begin
                        loader_we   = 1'b1;
                        loader_data = addr + i * data;
                        next_cycle();
                    end
                    loader_we = 1'b0;
                    cycles = 0;
                    while (!init_done && cycles < 4) begin
                        next_cycle();
                        cycles++;
                    end
                    if (!init_done) begin
                        timeout_count++;
                        $display("Timed out waiting for init_done in %0s", name);
                    end
                    u_checker.check_value(name, exp, checksum);
                end else if (kind == "peek") begin
                    u_checker.check_value(name, exp, {mem[addr[12:0] + 3],
                        mem[addr[12:0] + 2], mem[addr[12:0] + 1], mem[addr[12:0]]});
                end else if (kind == "load" || kind == "loadb" || kind == "busy" ||
                             kind == "rd") begin
                    dram_busy = (kind == "busy");
                    if (kind == "rd") begin
                        // Only the addressed window returns the test data
                        plic_rdata  = (addr[31:28] == 4'h5) ? data : ~data;
                        clint_rdata = (addr[31:28] == 4'h6) ? data : ~data;
                        fb_rdata    = (addr[31:24] == 8'h45) ? data : ~data;
                    end
                    cpu_drive(1'b0, 1'b1, addr, 32'h0, ctrl[2:0]);
                    u_checker.expect_read(name, exp, kind != "busy");
                    #5 u_checker.check_strobes(name, mask[5:0]);
                    next_cycle();
                    cpu_release();
                    dram_busy = 1'b0;
                    // Device read data holds through the result cycle
                    if (kind == "rd")
                        next_cycle();
                end else if (kind == "wr" || kind == "dwr") begin
                    cpu_drive(1'b1, 1'b0, addr, data, ctrl[2:0]);
                    #5 u_checker.check_strobes(name, mask[5:0]);
                    u_checker.check_wdata(name, data);
                    u_checker.check_value(name, addr & 32'h07ff_ffff, {5'h0, offset});
                    if (kind == "dwr")
                        u_checker.check_value(name, addr & 32'h07ff_ffff, dram_addr);
                    next_cycle();
                    cpu_release();
                end else if (kind == "print" || kind == "off") begin
                    cpu_drive(1'b1, 1'b0, addr, data, ctrl[2:0]);
                    next_cycle();
                    cpu_release();
                    wait_host_output(name, kind == "off", cycles);
                    u_checker.check_value(name, 32'd2, cycles);
                    if (kind == "print") begin
                        u_checker.check_value(name, exp, {24'h0, char_data});
                        next_cycle();
                        u_checker.check_value(name, 32'h0, {31'h0, char_we});
                    end else begin
                        u_checker.check_value(name, exp, {31'h0, finish});
                    end
                end
                // Chained loads go back to back, others get a short random gap
                if (kind != "loadb") begin
                    gap = $urandom % 4;
                    repeat (gap) next_cycle();
                end
            end
            $fclose(fd);
        end

        cycles = 0;
        while (u_checker.outstanding() > 0 && cycles < 10) begin
            next_cycle();
            cycles++;
        end
        if (u_checker.outstanding() > 0) begin
            timeout_count++;
            $display("Timed out waiting for outstanding load results");
        end

        $display("Errors: mismatches %0d, protocol %0d, timeouts %0d",
                 u_checker.mismatch_count, u_checker.protocol_count, timeout_count);
        if (u_checker.mismatch_count == 0 && u_checker.protocol_count == 0 &&
            timeout_count == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
